// ==== lcd_pkg.sv ====
package lcd_pkg;

    typedef logic [7:0] spi_byte_t;
    typedef logic [31:0] mem_addr_t;
    typedef logic [15:0] coord_t;   // coordinate as the display sees it

    typedef struct packed {
        logic dc;
        logic last;         // final pixel byte of a frame
        spi_byte_t data;
    } lcd_item_t;

    localparam logic DC_COMMAND = 1'b0;
    localparam logic DC_DATA = 1'b1;

    localparam spi_byte_t CASET_CMD = 8'h2A;    // column address set
    localparam spi_byte_t PASET_CMD = 8'h2B;    // page address set
    localparam spi_byte_t MEMWRITE_CMD = 8'h2C;

    typedef enum logic [1:0] {
        WINDOW,
        FRAME_CMD,
        PIXELS
    } fetch_state_t;

    typedef enum logic [1:0] {
        IDLE,
        START,
        BUSY
    } send_state_t;

endpackage

// ==== frame_fetch.sv ====
`timescale 1ns/1ns

module frame_fetch #(
    parameter int DISPLAY_X = 8,
    parameter int DISPLAY_Y = 4,
    parameter int DOWNSCALE_SHIFT = 1,
    parameter int FIFO_DEPTH = 4
) (
    input logic clk,
    input logic reset,
    input logic credit_return,
    input lcd_pkg::spi_byte_t mem_in,
    output lcd_pkg::mem_addr_t mem_addr,
    output logic push,
    output lcd_pkg::lcd_item_t push_item
);
    localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);
    localparam int Y_STRIDE = (DISPLAY_X * 2) >> DOWNSCALE_SHIFT;
    localparam lcd_pkg::coord_t X_END = lcd_pkg::coord_t'(DISPLAY_X - 1);
    localparam lcd_pkg::coord_t Y_END = lcd_pkg::coord_t'(DISPLAY_Y - 1);

    lcd_pkg::fetch_state_t state;
    logic [3:0] hdr_idx;
    lcd_pkg::coord_t x;
    lcd_pkg::coord_t y;
    logic byte_idx;
    logic [CREDIT_W-1:0] credits;
    logic issue;
    logic last_pixel;
    logic issue_mem;
    lcd_pkg::lcd_item_t hdr_item;
    lcd_pkg::lcd_item_t issue_item;

    logic s1_valid;
    logic s1_mem;
    lcd_pkg::lcd_item_t s1_item;
    lcd_pkg::coord_t s1_dx;
    lcd_pkg::coord_t s1_dy;
    logic s1_byte_idx;
    logic s2_valid;
    logic s2_mem;
    lcd_pkg::lcd_item_t s2_item;
    logic s3_valid;
    logic s3_mem;
    lcd_pkg::lcd_item_t s3_item;

    assign issue = (credits != '0);
    assign last_pixel = byte_idx && (x == X_END) && (y == Y_END);

    always_comb
    begin
        hdr_item.dc = lcd_pkg::DC_DATA;
        hdr_item.last = 1'b0;
        hdr_item.data = 8'h00;  // window starts at 0
        case (hdr_idx)
            4'd0:
            begin
                hdr_item.dc = lcd_pkg::DC_COMMAND;
                hdr_item.data = lcd_pkg::CASET_CMD;
            end
            4'd3: hdr_item.data = X_END[15:8];
            4'd4: hdr_item.data = X_END[7:0];
            4'd5:
            begin
                hdr_item.dc = lcd_pkg::DC_COMMAND;
                hdr_item.data = lcd_pkg::PASET_CMD;
            end
            4'd8: hdr_item.data = Y_END[15:8];
            4'd9: hdr_item.data = Y_END[7:0];
            default: ;
        endcase
    end

    always_comb
    begin
        issue_item.dc = lcd_pkg::DC_DATA;
        issue_item.last = 1'b0;
        issue_item.data = 8'h00;
        issue_mem = 1'b0;
        case (state)
            lcd_pkg::WINDOW: issue_item = hdr_item;
            lcd_pkg::FRAME_CMD:
            begin
                issue_item.dc = lcd_pkg::DC_COMMAND;
                issue_item.data = lcd_pkg::MEMWRITE_CMD;
            end
            default:
            begin
                issue_item.last = last_pixel;
                issue_mem = 1'b1;   // data filled from mem_in at stage 3
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= lcd_pkg::WINDOW;
            hdr_idx <= '0;
            x <= '0;
            y <= '0;
            byte_idx <= 1'b0;
            credits <= CREDIT_W'(FIFO_DEPTH);
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
            mem_addr <= '0;
        end
        else
        begin
            if (issue)
            begin
                case (state)
                    lcd_pkg::WINDOW:
                    begin
                        hdr_idx <= hdr_idx + 4'd1;
                        if (hdr_idx == 4'd9)
                            state <= lcd_pkg::FRAME_CMD;
                    end
                    lcd_pkg::FRAME_CMD: state <= lcd_pkg::PIXELS;
                    default:
                    begin
                        byte_idx <= ~byte_idx;
                        if (byte_idx)
                        begin
                            if (x == X_END)
                            begin
                                x <= '0;
                                y <= (y == Y_END) ? '0 : y + 16'd1;
                                if (y == Y_END)
                                    state <= lcd_pkg::FRAME_CMD;
                            end
                            else
                            begin
                                x <= x + 16'd1;
                            end
                        end
                    end
                endcase
            end

            case ({issue, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: ;
            endcase

            s1_valid <= issue;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
            if (s1_valid && s1_mem)
                mem_addr <= lcd_pkg::mem_addr_t'(s1_byte_idx)
                    + (lcd_pkg::mem_addr_t'(s1_dx) << 1)
                    + lcd_pkg::mem_addr_t'(s1_dy) * lcd_pkg::mem_addr_t'(Y_STRIDE);
        end
    end

    always_ff @(posedge clk)
    begin
        s1_item <= issue_item;
        s1_mem <= issue_mem;
        s1_dx <= x >> DOWNSCALE_SHIFT;  // downscale stage
        s1_dy <= y >> DOWNSCALE_SHIFT;
        s1_byte_idx <= byte_idx;
        s2_item <= s1_item;
        s2_mem <= s1_mem;
        s3_item <= s2_item;
        s3_mem <= s2_mem;
    end

    always_comb
    begin
        push_item = s3_item;
        if (s3_mem)
            push_item.data = mem_in;    // byte read at mem_addr last cycle
    end

    assign push = s3_valid;

    credits_bounded: assert property (@(posedge clk) disable iff (reset)
        credits <= CREDIT_W'(FIFO_DEPTH));

    // each item in the pipeline was paid for with a credit
    pipeline_within_credits: assert property (@(posedge clk) disable iff (reset)
        int'(s1_valid) + int'(s2_valid) + int'(s3_valid) + int'(credits) <= FIFO_DEPTH);

endmodule

// ==== byte_fifo.sv ====
`timescale 1ns/1ns

module byte_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input logic clk,
    input logic reset,
    input logic push,
    input logic pop,
    input lcd_pkg::lcd_item_t push_item,
    output lcd_pkg::lcd_item_t pop_item,
    output logic empty
);
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    lcd_pkg::lcd_item_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic full;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;  // any depth wraps
    endfunction

    assign empty = (count == '0);
    assign full = (count == CNT_W'(FIFO_DEPTH));
    assign pop_item = mem[rd_ptr];  // head of queue

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_item;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // credits upstream must keep these from ever firing
    no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        !(push && full));

    no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
        !(pop && empty));

endmodule

// ==== spi_byte_sender.sv ====
`timescale 1ns/1ns

module spi_byte_sender (
    input logic clk,
    input logic reset,
    input logic empty,
    input lcd_pkg::lcd_item_t pop_item,
    input logic spi_busy,
    output logic pop,
    output logic credit_return,
    output logic spi_start,
    output lcd_pkg::spi_byte_t spi_out,
    output logic dc,
    output logic cs,
    output logic frame_ended
);
    lcd_pkg::send_state_t state;
    logic last_r;   // byte in flight closes a frame

    assign pop = (state == lcd_pkg::IDLE) && !empty;
    assign credit_return = pop;     // slot freed in the FIFO

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= lcd_pkg::IDLE;
            spi_start <= 1'b0;
            spi_out <= 8'h00;
            dc <= lcd_pkg::DC_COMMAND;
            cs <= 1'b1;
            last_r <= 1'b0;
            frame_ended <= 1'b0;
        end
        else
        begin
            frame_ended <= 1'b0;
            case (state)
                lcd_pkg::IDLE:
                begin
                    if (pop)
                    begin
                        spi_out <= pop_item.data;
                        dc <= pop_item.dc;
                        last_r <= pop_item.last;
                        cs <= 1'b0;
                        spi_start <= 1'b1;
                        state <= lcd_pkg::START;
                    end
                    else
                    begin
                        cs <= 1'b1;     // release the bus when nothing is queued
                    end
                end
                lcd_pkg::START:
                begin
                    if (spi_busy)
                    begin
                        spi_start <= 1'b0;  // master took the byte
                        state <= lcd_pkg::BUSY;
                    end
                end
                default:
                begin
                    if (!spi_busy)
                    begin
                        frame_ended <= last_r;
                        state <= lcd_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    // byte and dc held for the master until it answers busy
    start_payload_stable: assert property (@(posedge clk) disable iff (reset)
        spi_start |=> (!spi_start || $stable({dc, spi_out})));

endmodule

// ==== lcd_stream_top.sv ====
`timescale 1ns/1ns

module lcd_stream_top #(
    parameter int DISPLAY_X = 240,
    parameter int DISPLAY_Y = 320,
    parameter int DOWNSCALE_SHIFT = 0,
    parameter int FIFO_DEPTH = 8
) (
    input logic clk,
    input logic reset,
    input logic spi_busy,
    input lcd_pkg::spi_byte_t mem_in,
    output logic spi_start,
    output lcd_pkg::spi_byte_t spi_out,
    output logic dc,
    output logic cs,
    output lcd_pkg::mem_addr_t mem_addr,
    output logic frame_ended
);
    logic push;
    logic pop;
    logic empty;
    logic credit_return;
    lcd_pkg::lcd_item_t push_item;
    lcd_pkg::lcd_item_t pop_item;

    frame_fetch #(
        .DISPLAY_X(DISPLAY_X),
        .DISPLAY_Y(DISPLAY_Y),
        .DOWNSCALE_SHIFT(DOWNSCALE_SHIFT),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) fetch_inst (
        .clk(clk),
        .reset(reset),
        .credit_return(credit_return),
        .mem_in(mem_in),
        .mem_addr(mem_addr),
        .push(push),
        .push_item(push_item)
    );

    byte_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) fifo_inst (
        .clk(clk),
        .reset(reset),
        .push(push),
        .pop(pop),
        .push_item(push_item),
        .pop_item(pop_item),
        .empty(empty)
    );

    spi_byte_sender sender_inst (
        .clk(clk),
        .reset(reset),
        .empty(empty),
        .pop_item(pop_item),
        .spi_busy(spi_busy),
        .pop(pop),
        .credit_return(credit_return),
        .spi_start(spi_start),
        .spi_out(spi_out),
        .dc(dc),
        .cs(cs),
        .frame_ended(frame_ended)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);
    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;   // released just after the edge like other inputs
    end
endmodule

// ==== tb_lcd_stream.sv ====
`timescale 1ns/1ns

module tb_lcd_stream;
    localparam int DISPLAY_X = 8;
    localparam int DISPLAY_Y = 4;
    localparam int DOWNSCALE_SHIFT = 1;
    localparam int FIFO_DEPTH = 4;
    localparam int FRAMES = 3;
    localparam int START_TIMEOUT = 100;
    localparam int RESET_TIMEOUT = 20;

    logic clk;
    logic reset;
    logic spi_busy;
    lcd_pkg::spi_byte_t mem_in;
    logic spi_start;
    lcd_pkg::spi_byte_t spi_out;
    logic dc;
    logic cs;
    lcd_pkg::mem_addr_t mem_addr;
    logic frame_ended;

    lcd_pkg::spi_byte_t mem_model [256];
    logic [7:0] prev_addr;
    lcd_pkg::lcd_item_t exp_q [$];
    int error_count;
    logic timed_out;

    tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(3)) clock_gen (.clk(clk), .reset(reset));

    lcd_stream_top #(
        .DISPLAY_X(DISPLAY_X),
        .DISPLAY_Y(DISPLAY_Y),
        .DOWNSCALE_SHIFT(DOWNSCALE_SHIFT),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) DUT (
        .clk(clk),
        .reset(reset),
        .spi_busy(spi_busy),
        .mem_in(mem_in),
        .spi_start(spi_start),
        .spi_out(spi_out),
        .dc(dc),
        .cs(cs),
        .mem_addr(mem_addr),
        .frame_ended(frame_ended)
    );

    // read port with one cycle of latency
    initial
    begin
        mem_in = 8'h00;
        prev_addr = '0;
        forever
        begin
            @(posedge clk);
            #1;
            mem_in = mem_model[prev_addr];
            prev_addr = mem_addr[7:0];
        end
    end

    task automatic compare_item(input lcd_pkg::lcd_item_t got, input lcd_pkg::lcd_item_t exp,
                                input int idx);
        if (got.dc !== exp.dc || got.data !== exp.data)
        begin
            error_count++;
            $display("ERR %0t ns: byte %0d is dc=%0b data=%02h, expected dc=%0b data=%02h",
                     $time, idx, got.dc, got.data, exp.dc, exp.data);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            error_count++;
            $display("ERR %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic void add_item(input logic dc_bit, input lcd_pkg::spi_byte_t data,
                                     input logic last);
        lcd_pkg::lcd_item_t item;
        item.dc = dc_bit;
        item.last = last;
        item.data = data;
        exp_q.push_back(item);
    endfunction

    task automatic fill_memory();
        for (int i = 0; i < 256; i++)
            mem_model[i] = lcd_pkg::spi_byte_t'($urandom);
    endtask

    task automatic build_expected();
        lcd_pkg::coord_t x_end;
        lcd_pkg::coord_t y_end;
        int addr;
        x_end = lcd_pkg::coord_t'(DISPLAY_X - 1);
        y_end = lcd_pkg::coord_t'(DISPLAY_Y - 1);
        add_item(lcd_pkg::DC_COMMAND, lcd_pkg::CASET_CMD, 1'b0);
        add_item(lcd_pkg::DC_DATA, 8'h00, 1'b0);
        add_item(lcd_pkg::DC_DATA, 8'h00, 1'b0);
        add_item(lcd_pkg::DC_DATA, x_end[15:8], 1'b0);
        add_item(lcd_pkg::DC_DATA, x_end[7:0], 1'b0);
        add_item(lcd_pkg::DC_COMMAND, lcd_pkg::PASET_CMD, 1'b0);
        add_item(lcd_pkg::DC_DATA, 8'h00, 1'b0);
        add_item(lcd_pkg::DC_DATA, 8'h00, 1'b0);
        add_item(lcd_pkg::DC_DATA, y_end[15:8], 1'b0);
        add_item(lcd_pkg::DC_DATA, y_end[7:0], 1'b0);
        for (int f = 0; f < FRAMES; f++)
        begin
            add_item(lcd_pkg::DC_COMMAND, lcd_pkg::MEMWRITE_CMD, 1'b0);
            for (int y = 0; y < DISPLAY_Y; y++)
            begin
                for (int x = 0; x < DISPLAY_X; x++)
                begin
                    for (int b = 0; b < 2; b++)
                    begin
                        addr = b + 2 * (x >> DOWNSCALE_SHIFT)
                            + (y >> DOWNSCALE_SHIFT) * ((2 * DISPLAY_X) >> DOWNSCALE_SHIFT);
                        add_item(lcd_pkg::DC_DATA, mem_model[addr],
                                 (y == DISPLAY_Y - 1) && (x == DISPLAY_X - 1) && (b == 1));
                    end
                end
            end
        end
    endtask

    // advance one clock and check frame_ended
    task automatic step_cycle(input logic fe_exp);
        @(posedge clk);
        #1;
        compare_flag(frame_ended, fe_exp, "frame_ended");
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        forever
        begin
            @(posedge clk);
            if (!reset)
                break;
            cycles++;
            if (cycles == RESET_TIMEOUT)
            begin
                $display("Timeout: reset was never released");
                timed_out = 1'b1;
                break;
            end
        end
    endtask

    task automatic wait_for_start(input logic fe_first, input logic first_byte);
        int cycles;
        logic fe_exp;
        cycles = 0;
        fe_exp = fe_first;
        forever
        begin
            step_cycle(fe_exp);
            fe_exp = 1'b0;
            if (spi_start)
                break;
            if (first_byte)
                compare_flag(cs, 1'b1, "cs before first byte");
            cycles++;
            if (cycles == START_TIMEOUT)
            begin
                $display("Timeout: the DUT raised no spi_start within %0d cycles", START_TIMEOUT);
                timed_out = 1'b1;
                break;
            end
        end
    endtask

    task automatic run_spi_slave();
        lcd_pkg::lcd_item_t got;
        logic fe_next;
        int delay;
        fe_next = 1'b0;
        for (int i = 0; i < exp_q.size(); i++)
        begin
            wait_for_start(fe_next, i == 0);
            if (timed_out)
                break;
            delay = $urandom_range(3, 0);
            for (int d = 0; d < delay; d++)
                step_cycle(1'b0);
            spi_busy = 1'b1;
            got.dc = dc;
            got.last = 1'b0;
            got.data = spi_out;
            compare_flag(cs, 1'b0, "cs at captured byte");
            compare_item(got, exp_q[i], i);
            delay = $urandom_range(6, 1);
            for (int d = 0; d < delay; d++)
                step_cycle(1'b0);
            spi_busy = 1'b0;
            fe_next = exp_q[i].last;    // pulse due in the next cycle
        end
        if (!timed_out)
            step_cycle(fe_next);
    endtask

    initial
    begin
        spi_busy = 1'b0;
        error_count = 0;
        timed_out = 1'b0;
        void'($urandom(32'h65e1));
        fill_memory();
        build_expected();
        wait_reset_release();
        if (!timed_out)
            run_spi_slave();
        $display("Errors: %0d value mismatches, %0d timeouts", error_count, timed_out ? 1 : 0);
        if (error_count == 0 && !timed_out)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end
endmodule

// ==== sim.f ====
lcd_pkg.sv
frame_fetch.sv
byte_fifo.sv
spi_byte_sender.sv
lcd_stream_top.sv
tb_clock_gen.sv
tb_lcd_stream.sv
